// File: hsid_pkg.sv
`default_nettype none

package hsid_pkg;

  // Bus and data widths
  localparam int hsid_word_width       = 32;  // OBI data and address width
  localparam int hsid_mem_access_width = 6;   // Band and pixel counters
  localparam int hsid_sample_width     = 16;  // Sample sits in bits 15:0 of a word
  localparam int hsid_sum_width        = 32;  // Band sum, wraps on overflow

  // OBI manager request, read-only use here
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [3:0]                 be;
    logic [hsid_word_width-1:0] addr;
    logic [hsid_word_width-1:0] wdata;
  } obi_req_t;

  // OBI response from memory
  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic [hsid_word_width-1:0] rdata;
  } obi_rsp_t;

  // Job parameters, sampled on start
  typedef struct packed {
    logic [hsid_word_width-1:0]       base_addr;  // Byte address of first band of pixel 0
    logic [hsid_mem_access_width-1:0] bands;      // 0 means 63
    logic [hsid_mem_access_width-1:0] pixels;     // 0 means 63
  } hsid_job_t;

  // Per-pixel result
  typedef struct packed {
    logic [hsid_sum_width-1:0]    sum;
    logic [hsid_sample_width-1:0] peak;
  } hsid_stats_t;

  // Burst reader FSM
  typedef enum logic [2:0] {HXOM_IDLE, HXOM_INIT, HXOM_READING, HXOM_DONE, HXOM_CLEAR}
    hsid_x_obi_mem_state_t;

  // Pixel sequencer FSM
  typedef enum logic [2:0] {SEQ_IDLE, SEQ_LAUNCH, SEQ_WAIT, SEQ_EMIT, SEQ_DONE}
    hsid_seq_state_t;

endpackage

`default_nettype wire

// File: hsid_x_obi_mem.sv
`default_nettype none

module hsid_x_obi_mem import hsid_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  output obi_req_t                         obi_req,
  input  obi_rsp_t                         obi_rsp,
  input  logic [hsid_word_width-1:0]       initial_addr,
  input  logic [hsid_mem_access_width-1:0] limit,
  output logic                             data_out_valid,
  output logic [hsid_word_width-1:0]       data_out,
  input  logic                             start,
  input  logic                             clear,
  output logic                             idle,
  output logic                             ready,
  output logic                             done
);

  hsid_x_obi_mem_state_t state, next_state;

  logic [hsid_mem_access_width-1:0] cur_limit;      // Latched burst length
  logic [hsid_mem_access_width:0]   requests;       // Addresses accepted this burst
  logic [hsid_mem_access_width:0]   reads;          // Words forwarded this burst
  logic [hsid_mem_access_width:0]   requests_next;
  logic [hsid_mem_access_width:0]   in_flight;      // Granted but not yet answered
  logic                             req_q;
  logic [hsid_word_width-1:0]       addr_q;
  logic                             accepted;
  logic                             finish_reading;

  assign accepted       = req_q && obi_rsp.gnt;  // Address phase completes
  assign requests_next  = requests + {{hsid_mem_access_width{1'b0}}, accepted};
  assign finish_reading = (reads >= {1'b0, cur_limit});

  // Read-only manager, full words
  always_comb begin
    obi_req      = '0;
    obi_req.req  = req_q;
    obi_req.be   = 4'hF;
    obi_req.addr = addr_q;
  end

  always_comb begin
    idle  = (state == HXOM_IDLE);
    ready = (state == HXOM_READING);
    done  = (state == HXOM_DONE);
    case (state)
      HXOM_IDLE:    next_state = (start && !clear) ? HXOM_INIT : HXOM_IDLE;
      // Hold off until responses of an aborted burst have drained
      HXOM_INIT:    next_state = clear ? HXOM_CLEAR :
                                 (in_flight == '0) ? HXOM_READING : HXOM_INIT;
      HXOM_READING: next_state = clear ? HXOM_CLEAR :
                                 finish_reading ? HXOM_DONE : HXOM_READING;
      HXOM_DONE:    next_state = HXOM_IDLE;
      HXOM_CLEAR:   next_state = HXOM_IDLE;
      default:      next_state = HXOM_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= HXOM_IDLE;
      req_q          <= 1'b0;
      addr_q         <= '0;
      cur_limit      <= '0;
      requests       <= '0;
      reads          <= '0;
      in_flight      <= '0;
      data_out_valid <= 1'b0;
    end else begin
      state          <= next_state;
      // Tracks outstanding reads in every state
      in_flight      <= in_flight + {{hsid_mem_access_width{1'b0}}, accepted}
                                  - {{hsid_mem_access_width{1'b0}}, obi_rsp.rvalid};
      data_out_valid <= 1'b0;
      case (state)
        HXOM_INIT: begin
          addr_q    <= initial_addr;
          cur_limit <= (limit == '0) ? '1 : limit;  // Zero length reads 63 words
          requests  <= '0;
          reads     <= '0;
        end
        HXOM_READING: begin
          // Keep asking until the last address has been accepted
          req_q <= !clear && (requests_next < {1'b0, cur_limit});
          if (accepted) begin
            addr_q   <= addr_q + (hsid_word_width / 8);  // Next band word
            requests <= requests_next;
          end
          if (obi_rsp.rvalid && !finish_reading) begin
            data_out_valid <= 1'b1;
            reads          <= reads + 1'b1;
          end
        end
        HXOM_CLEAR: req_q <= 1'b0;
        default: ;
      endcase
    end
  end

  // Read data capture
  always_ff @(posedge clk) begin
    if (state == HXOM_READING && obi_rsp.rvalid) data_out <= obi_rsp.rdata;
  end

endmodule

`default_nettype wire

// File: hsid_band_stats.sv
`default_nettype none

module hsid_band_stats import hsid_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pixel_start,   // Clears both accumulators
  input  logic                       sample_valid,
  input  logic [hsid_word_width-1:0] sample_word,
  output hsid_stats_t                stats
);

  logic [hsid_sample_width-1:0] sample;   // Band sample of the current word
  logic [hsid_sum_width-1:0]    sum_q;    // Running band sum
  logic [hsid_sample_width-1:0] peak_q;   // Largest sample so far
  logic                         new_peak;

  // Upper half of the word carries no data
  assign sample   = sample_word[hsid_sample_width-1:0];
  assign new_peak = (sample > peak_q);

  // Sum wraps at its width
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (pixel_start) begin
      sum_q <= '0;
    end else if (sample_valid) begin
      sum_q <= sum_q + hsid_sum_width'(sample);
    end
  end

  // Peak starts at zero, samples are unsigned
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peak_q <= '0;
    end else if (pixel_start) begin
      peak_q <= '0;
    end else if (sample_valid && new_peak) begin
      peak_q <= sample;
    end
  end

  // Presented every cycle, qualified by the sequencer
  assign stats = '{sum: sum_q, peak: peak_q};

endmodule

`default_nettype wire

// File: hsid_pixel_seq.sv
`default_nettype none

module hsid_pixel_seq import hsid_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  hsid_job_t                        job,
  input  logic                             start,
  input  logic                             clear,
  output logic [hsid_word_width-1:0]       burst_addr,
  output logic [hsid_mem_access_width-1:0] burst_len,
  output logic                             burst_start,
  output logic                             burst_clear,
  input  logic                             reader_done,
  output logic                             stats_valid,
  output logic                             job_done,
  output logic                             busy
);

  hsid_seq_state_t state, next_state;

  logic [hsid_mem_access_width-1:0] pixels;    // Latched pixel count
  logic [hsid_mem_access_width-1:0] pix_cnt;   // Pixels already emitted
  logic                             accept;
  logic                             last_pixel;

  // Trailing pulses still belong to the job
  assign busy        = (state != SEQ_IDLE) || stats_valid || job_done;
  assign accept      = start && !clear && !busy;   // Start while busy is dropped
  assign last_pixel  = (pix_cnt == pixels - 1'b1);
  assign burst_start = (state == SEQ_LAUNCH);      // Also clears the statistics
  assign burst_clear = clear;

  always_comb begin
    case (state)
      SEQ_IDLE:   next_state = accept ? SEQ_LAUNCH : SEQ_IDLE;
      SEQ_LAUNCH: next_state = SEQ_WAIT;
      SEQ_WAIT:   next_state = reader_done ? SEQ_EMIT : SEQ_WAIT;
      SEQ_EMIT:   next_state = last_pixel ? SEQ_DONE : SEQ_LAUNCH;
      SEQ_DONE:   next_state = SEQ_IDLE;
      default:    next_state = SEQ_IDLE;
    endcase
    if (clear) next_state = SEQ_IDLE;  // Abort from anywhere
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= SEQ_IDLE;
      burst_addr  <= '0;
      burst_len   <= '0;
      pixels      <= '0;
      pix_cnt     <= '0;
      stats_valid <= 1'b0;
      job_done    <= 1'b0;
    end else begin
      state       <= next_state;
      // Registered so stats settle after the last sample
      stats_valid <= (state == SEQ_EMIT) && !clear;
      job_done    <= (state == SEQ_DONE) && !clear;
      if (accept) begin
        burst_addr <= job.base_addr;
        burst_len  <= (job.bands == '0) ? '1 : job.bands;    // Zero counts mean 63
        pixels     <= (job.pixels == '0) ? '1 : job.pixels;
        pix_cnt    <= '0;
      end else if (state == SEQ_EMIT) begin
        // Pixels are packed, four bytes per band
        burst_addr <= burst_addr + hsid_word_width'({burst_len, 2'b00});
        pix_cnt    <= pix_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hsid_top.sv
`default_nettype none

module hsid_top import hsid_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  hsid_job_t   job,
  input  logic        start,
  input  logic        clear,
  output obi_req_t    obi_req,
  input  obi_rsp_t    obi_rsp,
  output hsid_stats_t stats,
  output logic        stats_valid,
  output logic        busy,
  output logic        job_done
);

  logic [hsid_word_width-1:0]       burst_addr;
  logic [hsid_mem_access_width-1:0] burst_len;
  logic                             burst_start;   // Doubles as pixel_start
  logic                             burst_clear;
  logic                             reader_done;
  logic [hsid_word_width-1:0]       band_word;
  logic                             band_valid;

  hsid_pixel_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .job         (job),
    .start       (start),
    .clear       (clear),
    .burst_addr  (burst_addr),
    .burst_len   (burst_len),
    .burst_start (burst_start),
    .burst_clear (burst_clear),
    .reader_done (reader_done),
    .stats_valid (stats_valid),
    .job_done    (job_done),
    .busy        (busy)
  );

  // Sequencer paces bursts on done alone
  hsid_x_obi_mem u_reader (
    .clk            (clk),
    .rst_n          (rst_n),
    .obi_req        (obi_req),
    .obi_rsp        (obi_rsp),
    .initial_addr   (burst_addr),
    .limit          (burst_len),
    .data_out_valid (band_valid),
    .data_out       (band_word),
    .start          (burst_start),
    .clear          (burst_clear),
    .idle           (),
    .ready          (),
    .done           (reader_done)
  );

  hsid_band_stats u_stats (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel_start  (burst_start),
    .sample_valid (band_valid),
    .sample_word  (band_word),
    .stats        (stats)
  );

endmodule

`default_nettype wire

// File: hsid_clk_gen.sv
`default_nettype none

module hsid_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 5;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;  // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: hsid_obi_mem_model.sv
`default_nettype none

module hsid_obi_mem_model import hsid_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  obi_req_t obi_req,
  output obi_rsp_t obi_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  integer      seed = 69011;
  int          edge_cnt;        // Rising edges since reset
  int          last_due;        // Cycle of the newest queued response
  logic [31:0] pend_addr[$];    // Granted addresses awaiting rvalid
  int          pend_due[$];

  // Low half is word index plus one, upper half zero
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [15:0] idx;
    idx = addr[17:2];
    return {16'h0000, idx + 16'd1};
  endfunction

  always @(posedge clk or negedge rst_n) begin : respond
    logic [31:0] roll;
    int          due;
    if (!rst_n) begin
      obi_rsp  <= '0;
      edge_cnt = 0;
      last_due = 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      edge_cnt = edge_cnt + 1;
      // Address phase of the cycle just ended
      if (obi_req.req && obi_rsp.gnt) begin
        roll = $random(seed);
        due  = edge_cnt + (roll % 3);   // One to three cycles after the grant
        if (due <= last_due) due = last_due + 1;  // Keep order, one per cycle
        last_due = due;
        pend_addr.push_back(obi_req.addr);
        pend_due.push_back(due);
      end
      roll = $random(seed);
      obi_rsp.gnt <= roll[0];  // Grant half the time
      if (pend_due.size() > 0 && pend_due[0] <= edge_cnt) begin
        obi_rsp.rvalid <= 1'b1;
        obi_rsp.rdata  <= word_at(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        obi_rsp.rvalid <= 1'b0;
        obi_rsp.rdata  <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hsid_checker.sv
`default_nettype none

module hsid_checker import hsid_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     clear,
  input obi_req_t obi_req,
  input obi_rsp_t obi_rsp,
  input logic     stats_valid,
  input logic     job_done,
  input logic     busy
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;  // Failed assertion count

  // Address phase frozen until granted, abort excepted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req.req && !obi_rsp.gnt && !clear |=> $stable(obi_req))
  else begin
    $error("OBI request changed while waiting for grant");
    failures++;
  end

  // Pulses come out of a running job that saw no clear
  a_pulse_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (stats_valid || job_done) |-> $past(busy && !clear))
  else begin
    $error("Result pulse without a busy, uncleared cycle before it");
    failures++;
  end

  // Last pixel and job end are separate cycles
  a_pulse_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(stats_valid && job_done))
  else begin
    $error("stats_valid and job_done in the same cycle");
    failures++;
  end

endmodule

`default_nettype wire

// File: tb_hsid_top.sv
`default_nettype none

module tb_hsid_top import hsid_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_timeout = 20;
  localparam int job_timeout   = 20000;  // Cycles for one whole job
  localparam int idle_timeout  = 4;      // Cycles for busy to fall after clear
  localparam int quiet_window  = 200;    // Watched after an abort

  logic        clk;
  logic        rst_n;
  hsid_job_t   job;
  logic        start;
  logic        clear;
  obi_req_t    obi_req;
  obi_rsp_t    obi_rsp;
  hsid_stats_t stats;
  logic        stats_valid;
  logic        busy;
  logic        job_done;

  logic [31:0] job_base[$];
  int          job_bands[$];
  int          job_pixels[$];
  int          job_clear_after[$];
  int          job_count[$];       // Result lines per job
  int          exp_sum[$];
  int          exp_peak[$];
  int          stats_seen;         // Pixels checked so far
  int          stats_budget;       // Pixels allowed so far
  logic        aborted;            // No pulse legal any more

  hsid_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  hsid_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .job         (job),
    .start       (start),
    .clear       (clear),
    .obi_req     (obi_req),
    .obi_rsp     (obi_rsp),
    .stats       (stats),
    .stats_valid (stats_valid),
    .busy        (busy),
    .job_done    (job_done)
  );

  hsid_obi_mem_model u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .obi_req (obi_req),
    .obi_rsp (obi_rsp)
  );

  bind hsid_top hsid_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (clear),
    .obi_req     (obi_req),
    .obi_rsp     (obi_rsp),
    .stats_valid (stats_valid),
    .job_done    (job_done),
    .busy        (busy)
  );

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] base;
    int          bands;
    int          pixels;
    int          clr;
    int          sum;
    int          peak;
    fd = $fopen("hsid_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open hsid_trace.txt");
      stop_on_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
          n = 0;  // Comment or blank
        end else if (line[0] == "J") begin
          n = $sscanf(line, "J %h %d %d %d", base, bands, pixels, clr);
          if (n != 4) begin
            $display("Job line in the trace is incomplete: %s", line);
            stop_on_failure();
          end else begin
            job_base.push_back(base);
            job_bands.push_back(bands);
            job_pixels.push_back(pixels);
            job_clear_after.push_back(clr);
            job_count.push_back(0);
          end
        end else if (line[0] == "R" && job_count.size() > 0) begin
          n = $sscanf(line, "R %d %d", sum, peak);
          if (n != 2) begin
            $display("Result line in the trace is incomplete: %s", line);
            stop_on_failure();
          end else begin
            exp_sum.push_back(sum);
            exp_peak.push_back(peak);
            job_count[job_count.size()-1] = job_count[job_count.size()-1] + 1;
          end
        end else begin
          $display("Trace line not understood: %s", line);
          stop_on_failure();
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      if (cycles >= reset_timeout) begin
        $display("Reset was never released");
        stop_on_failure();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  task automatic wait_job_done();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (job_done !== 1'b1) begin
      if (cycles >= job_timeout) begin
        $display("job_done did not arrive within %0d cycles", job_timeout);
        stop_on_failure();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (busy !== 1'b0) begin
      if (cycles >= idle_timeout) begin
        $display("busy still high %0d cycles after clear", cycles);
        stop_on_failure();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  task automatic run_job(input int j);
    hsid_job_t cur;
    hsid_job_t decoy;
    cur.base_addr   = job_base[j];
    cur.bands       = hsid_mem_access_width'(job_bands[j]);
    cur.pixels      = hsid_mem_access_width'(job_pixels[j]);
    decoy           = cur;
    decoy.base_addr = cur.base_addr + 32'h1000;  // Would give wrong sums if taken
    decoy.bands     = 6'd2;
    decoy.pixels    = 6'd1;
    stats_budget    = stats_budget + job_count[j];
    aborted         = 1'b0;
    @(posedge clk);
    job   <= cur;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    job   <= decoy;  // Start while busy
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    job   <= cur;
    if (job_clear_after[j] > 0) begin
      repeat (job_clear_after[j] - 3) @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      wait_idle();
      @(posedge clk);
      aborted = 1'b1;
      repeat (quiet_window) @(posedge clk);  // Monitor flags any late pulse
    end else begin
      wait_job_done();
      @(posedge clk);
    end
    check_value(stats_seen, stats_budget, "stats_valid count");
  endtask

  // Result monitor, sampled on the rising edge
  always @(posedge clk) begin
    if (rst_n === 1'b1) begin
      if (UUT.u_checker.failures != 0) begin
        $display("A protocol assertion failed before %0t ns", $time);
        stop_on_failure();
      end else if (stats_valid && (aborted || stats_seen >= stats_budget)) begin
        $display("Unexpected stats_valid at %0t ns", $time);
        stop_on_failure();
      end else if (job_done && aborted) begin
        $display("job_done at %0t ns after the job was cleared", $time);
        stop_on_failure();
      end else if (stats_valid) begin
        check_value(stats.sum, exp_sum[stats_seen], "pixel band sum");
        check_value(stats.peak, exp_peak[stats_seen], "pixel peak");
        stats_seen = stats_seen + 1;
      end
    end
  end

  // Reads only, all four byte lanes
  always @(posedge clk) begin
    if (rst_n === 1'b1 && obi_req.req === 1'b1) begin
      check_value(obi_req.we, 1'b0, "obi_req.we");
      check_value(obi_req.be, 4'hF, "obi_req.be");
    end
  end

  initial begin
    job          = '0;
    start        = 1'b0;
    clear        = 1'b0;
    stats_seen   = 0;
    stats_budget = 0;
    aborted      = 1'b0;
    load_trace();
    wait_reset_release();
    @(posedge clk);
    check_value(obi_req.req, 1'b0, "obi_req.req after reset");
    check_value(busy, 1'b0, "busy after reset");
    check_value(stats_valid, 1'b0, "stats_valid after reset");
    check_value(job_done, 1'b0, "job_done after reset");
    for (int j = 0; j < job_base.size(); j++) begin
      run_job(j);
    end
    check_value(UUT.u_checker.failures, 0, "failed assertions");
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: hsid_top.f
hsid_pkg.sv
hsid_x_obi_mem.sv
hsid_band_stats.sv
hsid_pixel_seq.sv
hsid_top.sv
hsid_clk_gen.sv
hsid_obi_mem_model.sv
hsid_checker.sv
tb_hsid_top.sv

// File: hsid_trace.txt
# J <base hex> <bands> <pixels> <clear delay in cycles after start, above 3, 0 for none>
# R <band sum> <peak sample> per completed pixel, decimal
J 20 4 1 0
R 42 12
J 100 5 3 0
R 335 69
R 360 74
R 385 79
J 400 0 2 0
R 18144 319
R 22113 382
J 800 8 4 6
J 40 3 2 0
R 54 19
R 63 22
J 0 1 2 0
R 1 1
R 2 2
